/* common/divsqrt_consts.svh */
// ------------------------------------------------
// Build-time constants of the divide / square-root unit
// Include wherever a width or stage count is needed
// The package pulls this in for its type widths
// ------------------------------------------------

`ifndef DIVSQRT_CONSTS_SVH
`define DIVSQRT_CONSTS_SVH

// ------------------------------------------------
// Datapath
// ------------------------------------------------
// Operand and result width, must be even for the root
`define DS_WIDTH 32
// Width of the opaque tag returned with each result
`define DS_TAG_WIDTH 4

// ------------------------------------------------
// Elastic pipelines
// ------------------------------------------------
// Register stages in front of the control FSM
`define DS_IN_REGS 1
// Register stages behind the control FSM
`define DS_OUT_REGS 1

`endif

/* common/divsqrt_pkg.sv */
// ------------------------------------------------
// Shared types of the integer divide / sqrt unit
// Operation code, operand, tag and status types,
// plus the payload structs carried by the pipelines
// Import with a wildcard in the module header
// ------------------------------------------------

`include "divsqrt_consts.svh"

package divsqrt_pkg;

  // Operation select, one bit
  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } op_e;

  // Operand and result word
  typedef logic [`DS_WIDTH-1:0] operand_t;

  // Opaque request identifier, echoed with the result
  typedef logic [`DS_TAG_WIDTH-1:0] tag_t;

  // Status flags of one operation
  typedef struct packed {
    // Division with a divisor of zero
    logic div_zero;
    // Non-zero remainder left over
    logic inexact;
  } status_t;

  // ------------------------------------------------
  // Pipeline payloads
  // ------------------------------------------------
  // Request into the input pipeline, 69 bits
  typedef struct packed {
    op_e      op;
    operand_t a;
    operand_t b;
    tag_t     tag;
  } in_req_t;

  // Response out of the output pipeline, 38 bits
  typedef struct packed {
    operand_t result;
    status_t  status;
    tag_t     tag;
  } out_rsp_t;

endpackage

/* rtl/pipe_stages.sv */
// ------------------------------------------------
// Elastic valid/ready register chain
// Payload type and stage count set by parameters;
// zero stages gives a plain wire. flush_i drops
// every valid in the chain in the same cycle
// ------------------------------------------------

`timescale 1ns/1ps

module pipe_stages import divsqrt_pkg::*; #(
  parameter type         payload_t = in_req_t,
  parameter int unsigned NumStages = 1
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     flush_i,
  // Upstream side
  input  logic     in_valid_i,
  input  payload_t in_data_i,
  output logic     in_ready_o,
  // Downstream side
  output logic     out_valid_o,
  output payload_t out_data_o,
  input  logic     out_ready_i,
  // Any stage holding valid data
  output logic     busy_o
);

  // Index i is the value after i register stages
  logic     valid_q [0:NumStages];
  payload_t data_q  [0:NumStages];
  // Ready is combinational through the whole chain
  logic     ready   [0:NumStages];

  // Chain entry comes straight from the ports
  assign valid_q[0] = in_valid_i;
  assign data_q[0]  = in_data_i;
  assign in_ready_o = ready[0];

  for (genvar i = 0; i < NumStages; i++) begin : gen_stage
    logic load;
    // Advance if next stage moves on or only holds a bubble
    assign ready[i] = ready[i+1] | ~valid_q[i+1];
    // Capture data only for a real item
    assign load = ready[i] & valid_q[i];

    always_ff @(posedge clk_i) begin
      if (rst_i || flush_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    // Payload register, enable only
    always_ff @(posedge clk_i) begin
      if (load) begin
        data_q[i+1] <= data_q[i];
      end
    end
  end

  // Chain exit
  assign ready[NumStages] = out_ready_i;
  assign out_valid_o      = valid_q[NumStages];
  assign out_data_o       = data_q[NumStages];

  // OR of the registered valids, zero for a wire
  always_comb begin
    busy_o = 1'b0;
    for (int unsigned i = 1; i <= NumStages; i++) begin
      busy_o = busy_o | valid_q[i];
    end
  end

  // Held output must not change under back-pressure
  a_hold_stable: assert property (@(posedge clk_i) disable iff (rst_i || flush_i)
    out_valid_o && !out_ready_i |=> $stable(out_data_o));

endmodule

/* divsqrt/divsqrt_iter.sv */
// ------------------------------------------------
// Iterative integer divide and square-root core
// Restoring shift-subtract divide, one quotient bit
// per cycle, and digit-by-digit restoring root, one
// root bit per cycle. Operands are sampled on
// start_i, done_o pulses once, and result and flags
// stay stable until the next start
// ------------------------------------------------

`timescale 1ns/1ps

module divsqrt_iter import divsqrt_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     kill_i,
  input  logic     start_i,
  input  op_e      op_i,
  input  operand_t a_i,
  input  operand_t b_i,
  output logic     ready_o,
  output logic     done_o,
  output operand_t result_o,
  output status_t  status_o
);

  localparam int unsigned W    = $bits(operand_t);
  localparam int unsigned CntW = $clog2(W);
  // Iterations left after the one done on the start edge
  localparam logic [CntW-1:0] DivIters  = CntW'(W - 1);
  localparam logic [CntW-1:0] SqrtIters = CntW'(W / 2 - 1);

  // ------------------------------------------------
  // State
  // ------------------------------------------------
  op_e             op_q;
  // Divisor, kept for the zero check
  operand_t        div_q;
  // Dividend or radicand, shifted out at the top
  operand_t        opd_q;
  // Partial remainder
  operand_t        rem_q;
  // Quotient or root, shifted in at the bottom
  operand_t        res_q;
  status_t         status_q;
  logic [CntW-1:0] cnt_q;
  logic            run_q;
  logic            done_q;

  // Step inputs, from the ports on start
  op_e             src_op;
  operand_t        src_div;
  operand_t        src_opd;
  operand_t        src_rem;
  operand_t        src_res;
  // Trial subtraction, two spare bits for the root
  logic [W+1:0]    shifted;
  logic [W+1:0]    trial;
  logic [W+1:0]    diff;
  logic            fits;
  operand_t        opd_nxt;
  operand_t        rem_nxt;
  operand_t        res_nxt;
  logic            last_iter;
  logic            div_zero;

  // ------------------------------------------------
  // One iteration
  // ------------------------------------------------
  always_comb begin
    if (start_i) begin
      // First step runs on the start edge
      src_op  = op_i;
      src_div = b_i;
      src_opd = a_i;
      src_rem = '0;
      src_res = '0;
    end else begin
      src_op  = op_q;
      src_div = div_q;
      src_opd = opd_q;
      src_rem = rem_q;
      src_res = res_q;
    end

    if (src_op == OP_DIV) begin
      // Bring down one dividend bit, try the divisor
      shifted = {1'b0, src_rem, src_opd[W-1]};
      trial   = {2'b00, src_div};
      opd_nxt = src_opd << 1;
    end else begin
      // Bring down two radicand bits, try 4*root+1
      shifted = {src_rem, src_opd[W-1 -: 2]};
      trial   = {src_res, 2'b01};
      opd_nxt = src_opd << 2;
    end

    fits    = (shifted >= trial);
    diff    = shifted - trial;
    // Restore on a failed trial
    rem_nxt = fits ? diff[W-1:0] : shifted[W-1:0];
    res_nxt = {src_res[W-2:0], fits};
  end

  // Zero divisor gives all ones and is still counted out
  assign last_iter = run_q && (cnt_q == CntW'(1));
  assign div_zero  = (op_q == OP_DIV) && (div_q == '0);

  // ------------------------------------------------
  // Control
  // ------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i || kill_i) begin
      run_q  <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        run_q <= 1'b1;
        cnt_q <= (op_i == OP_DIV) ? DivIters : SqrtIters;
      end else if (run_q) begin
        cnt_q <= cnt_q - 1'b1;
        if (last_iter) begin
          run_q  <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // Datapath
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      op_q     <= op_i;
      div_q    <= b_i;
      status_q <= '0;
    end
    if (start_i || run_q) begin
      opd_q <= opd_nxt;
      rem_q <= rem_nxt;
      res_q <= res_nxt;
    end
    // Flags from the final remainder
    if (last_iter) begin
      status_q.div_zero <= div_zero;
      status_q.inexact  <= ~div_zero & (rem_nxt != '0);
    end
  end

  assign ready_o  = ~run_q;
  assign done_o   = done_q;
  assign result_o = res_q;
  assign status_o = status_q;

  // Controller must wait for the core between operations
  a_no_start_busy: assert property (@(posedge clk_i) disable iff (rst_i)
    start_i |-> ready_o);

endmodule

/* divsqrt/divsqrt_ctrl.sv */
// ------------------------------------------------
// Control FSM of the divide / square-root unit
// Starts the iterative core on a valid request,
// keeps the tag of the running operation and
// offers the result downstream, holding it under
// back-pressure. A new operation can start in the
// cycle the previous result is taken
// ------------------------------------------------

`timescale 1ns/1ps

module divsqrt_ctrl import divsqrt_pkg::*; (
  input  logic clk_i,
  input  logic rst_i,
  input  logic flush_i,
  // Request side from the input pipeline
  input  logic in_valid_i,
  input  tag_t in_tag_i,
  output logic in_ready_o,
  // Core handshake
  output logic start_o,
  input  logic unit_ready_i,
  input  logic unit_done_i,
  // Result side to the output pipeline
  output logic out_valid_o,
  output tag_t out_tag_o,
  input  logic out_ready_i,
  // Operation in flight
  output logic busy_o
);

  // ------------------------------------------------
  // FSM
  // ------------------------------------------------
  // IDLE waits, BUSY runs the core, HOLD keeps a result
  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    HOLD
  } state_e;

  state_e state_q;
  state_e state_d;
  // FSM side of the acceptance condition
  logic   fsm_ready;
  // Tag of the operation in the core
  tag_t   tag_q;

  always_comb begin
    state_d     = state_q;
    fsm_ready   = 1'b0;
    out_valid_o = 1'b0;
    busy_o      = 1'b0;

    unique case (state_q)
      IDLE: begin
        fsm_ready = 1'b1;
      end
      BUSY: begin
        busy_o = 1'b1;
        // Result is offered in the cycle the core finishes
        if (unit_done_i) begin
          out_valid_o = 1'b1;
          if (out_ready_i) begin
            fsm_ready = 1'b1;
            state_d   = IDLE;
          end else begin
            state_d = HOLD;
          end
        end
      end
      HOLD: begin
        busy_o      = 1'b1;
        out_valid_o = 1'b1;
        // Core output stays stable until the next start
        if (out_ready_i) begin
          fsm_ready = 1'b1;
          state_d   = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase

    // Take a request only if the core can start it now
    in_ready_o = fsm_ready & unit_ready_i & ~flush_i;
    start_o    = in_valid_i & in_ready_o;
    // Back-to-back start overrides the return to IDLE
    if (start_o) begin
      state_d = BUSY;
    end

    // Flush drops everything in flight
    if (flush_i) begin
      busy_o      = 1'b0;
      out_valid_o = 1'b0;
      state_d     = IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Tag follows the operation and is loaded on start
  always_ff @(posedge clk_i) begin
    if (start_o) begin
      tag_q <= in_tag_i;
    end
  end

  assign out_tag_o = tag_q;

  // Core reports done only for an operation this FSM started
  a_done_busy: assert property (@(posedge clk_i) disable iff (rst_i)
    unit_done_i |-> state_q == BUSY);

  // Offered result stays offered until taken or flushed
  a_out_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && !out_ready_i |=> out_valid_o || flush_i);

endmodule

/* rtl/divsqrt_top.sv */
// ------------------------------------------------
// Top level of the integer divide / sqrt unit
// Input pipeline, control FSM, iterative core and
// output pipeline. Requests and results use a
// valid/ready handshake; flush_i cancels all work
// ------------------------------------------------

`timescale 1ns/1ps
`include "divsqrt_consts.svh"

module divsqrt_top import divsqrt_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     flush_i,
  // Request
  input  logic     in_valid_i,
  input  op_e      op_i,
  input  operand_t a_i,
  input  operand_t b_i,
  input  tag_t     tag_i,
  output logic     in_ready_o,
  // Response
  output logic     out_valid_o,
  output operand_t result_o,
  output status_t  status_o,
  output tag_t     tag_o,
  input  logic     out_ready_i,
  // Anything in flight
  output logic     busy_o
);

  in_req_t  in_req;
  in_req_t  req_q;
  logic     req_valid;
  logic     req_ready;
  out_rsp_t rsp_d;
  out_rsp_t rsp_q;
  logic     rsp_valid;
  logic     rsp_ready;
  logic     start;
  logic     unit_ready;
  logic     unit_done;
  operand_t unit_result;
  status_t  unit_status;
  tag_t     rsp_tag;
  logic     in_busy;
  logic     ctrl_busy;
  logic     out_busy;

  // ------------------------------------------------
  // Input side
  // ------------------------------------------------
  assign in_req = '{op: op_i, a: a_i, b: b_i, tag: tag_i};

  pipe_stages #(
    .payload_t (in_req_t),
    .NumStages (`DS_IN_REGS)
  ) in_pipe (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_data_i   (in_req),
    .in_ready_o  (in_ready_o),
    .out_valid_o (req_valid),
    .out_data_o  (req_q),
    .out_ready_i (req_ready),
    .busy_o      (in_busy)
  );

  divsqrt_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .flush_i      (flush_i),
    .in_valid_i   (req_valid),
    .in_tag_i     (req_q.tag),
    .in_ready_o   (req_ready),
    .start_o      (start),
    .unit_ready_i (unit_ready),
    .unit_done_i  (unit_done),
    .out_valid_o  (rsp_valid),
    .out_tag_o    (rsp_tag),
    .out_ready_i  (rsp_ready),
    .busy_o       (ctrl_busy)
  );

  // Operands go straight to the core, sampled on start
  divsqrt_iter u_iter (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .kill_i   (flush_i),
    .start_i  (start),
    .op_i     (req_q.op),
    .a_i      (req_q.a),
    .b_i      (req_q.b),
    .ready_o  (unit_ready),
    .done_o   (unit_done),
    .result_o (unit_result),
    .status_o (unit_status)
  );

  // ------------------------------------------------
  // Output side
  // ------------------------------------------------
  // Core result with the tag held by the FSM
  assign rsp_d = '{result: unit_result, status: unit_status, tag: rsp_tag};

  pipe_stages #(
    .payload_t (out_rsp_t),
    .NumStages (`DS_OUT_REGS)
  ) out_pipe (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .in_valid_i  (rsp_valid),
    .in_data_i   (rsp_d),
    .in_ready_o  (rsp_ready),
    .out_valid_o (out_valid_o),
    .out_data_o  (rsp_q),
    .out_ready_i (out_ready_i),
    .busy_o      (out_busy)
  );

  assign result_o = rsp_q.result;
  assign status_o = rsp_q.status;
  assign tag_o    = rsp_q.tag;
  assign busy_o   = in_busy | ctrl_busy | out_busy;

endmodule

/* sim/tb_divsqrt.sv */
// ------------------------------------------------
// Directed testbench of the integer divide / sqrt unit
// Drives requests into the top level and checks each
// result against a behavioral model. Covers reset,
// divide, root, divide by zero, back-pressure with
// ordering, and flush. Stops at the first mismatch
// ------------------------------------------------

`timescale 1ns/1ps
`include "divsqrt_consts.svh"

module tb_divsqrt import divsqrt_pkg::*; ();

  localparam int unsigned W       = `DS_WIDTH;
  // Cycle limit for any single wait
  localparam int unsigned Timeout = 200;

  typedef logic [2*W-1:0] wide_t;

  logic     clk;
  logic     rst;
  logic     flush;
  logic     in_valid;
  op_e      op;
  operand_t a;
  operand_t b;
  tag_t     tag;
  logic     in_ready;
  logic     out_valid;
  operand_t result;
  status_t  status;
  tag_t     tag_out;
  logic     out_ready;
  logic     busy;
  // Fibonacci LFSR state
  logic [31:0] lfsr_q;

  divsqrt_top uut (
    .clk_i       (clk),
    .rst_i       (rst),
    .flush_i     (flush),
    .in_valid_i  (in_valid),
    .op_i        (op),
    .a_i         (a),
    .b_i         (b),
    .tag_i       (tag),
    .in_ready_o  (in_ready),
    .out_valid_o (out_valid),
    .result_o    (result),
    .status_o    (status),
    .tag_o       (tag_out),
    .out_ready_i (out_ready),
    .busy_o      (busy)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------
  // Taps 32, 22, 2, 1; one step per bit taken
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic operand_t rand_bits(input int unsigned n);
    operand_t v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      v = {v[W-2:0], lfsr_bit()};
    end
    return v;
  endfunction

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_operand(input string name, input operand_t exp, input operand_t act);
    if (act !== exp) begin
      abort_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_status(input string name, input status_t exp, input status_t act);
    if (act !== exp) begin
      abort_run($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_tag(input string name, input tag_t exp, input tag_t act);
    if (act !== exp) begin
      abort_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  // Quotient, floor root and flags straight from the arithmetic
  task automatic model_result(input op_e op_v, input operand_t a_v, input operand_t b_v,
                              output operand_t res_v, output status_t st_v);
    operand_t cand;
    wide_t    sq;
    st_v  = '0;
    res_v = '0;
    if (op_v == OP_DIV) begin
      if (b_v == '0) begin
        res_v         = '1;
        st_v.div_zero = 1'b1;
      end else begin
        res_v        = a_v / b_v;
        st_v.inexact = (a_v % b_v) != '0;
      end
    end else begin
      // Keep each root bit whose square still fits
      for (int i = W / 2 - 1; i >= 0; i--) begin
        cand = res_v | (operand_t'(1) << i);
        sq   = wide_t'(cand) * wide_t'(cand);
        if (sq <= wide_t'(a_v)) begin
          res_v = cand;
        end
      end
      st_v.inexact = (wide_t'(res_v) * wide_t'(res_v)) != wide_t'(a_v);
    end
  endtask

  task automatic drive_request(input op_e op_v, input operand_t a_v, input operand_t b_v,
                               input tag_t tag_v);
    in_valid = 1'b1;
    op       = op_v;
    a        = a_v;
    b        = b_v;
    tag      = tag_v;
  endtask

  // Entered and left 1 ns after a rising edge
  task automatic send_request(input op_e op_v, input operand_t a_v, input operand_t b_v,
                              input tag_t tag_v);
    int unsigned cnt;
    cnt = 0;
    drive_request(op_v, a_v, b_v, tag_v);
    @(negedge clk);
    while (!in_ready) begin
      cnt++;
      if (cnt > Timeout) begin
        abort_run("Timeout: request was never accepted");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic wait_result(output operand_t res_v, output status_t st_v, output tag_t tag_v);
    int unsigned cnt;
    cnt       = 0;
    out_ready = 1'b1;
    @(negedge clk);
    while (!out_valid) begin
      cnt++;
      if (cnt > Timeout) begin
        abort_run("Timeout: no result came out of the unit");
      end
      @(negedge clk);
    end
    res_v = result;
    st_v  = status;
    tag_v = tag_out;
    @(posedge clk);
    #1;
  endtask

  task automatic run_op(input string name, input op_e op_v, input operand_t a_v,
                        input operand_t b_v);
    operand_t exp_res;
    operand_t got_res;
    status_t  exp_st;
    status_t  got_st;
    tag_t     tag_v;
    tag_t     got_tag;
    tag_v = tag_t'(rand_bits(`DS_TAG_WIDTH));
    model_result(op_v, a_v, b_v, exp_res, exp_st);
    send_request(op_v, a_v, b_v, tag_v);
    wait_result(got_res, got_st, got_tag);
    check_operand({name, " result"}, exp_res, got_res);
    check_status({name, " status"}, exp_st, got_st);
    check_tag({name, " tag"}, tag_v, got_tag);
  endtask

  // ------------------------------------------------
  // Tests
  // ------------------------------------------------
  task automatic test_reset();
    @(negedge clk);
    check_bit("reset out_valid", 1'b0, out_valid);
    check_bit("reset busy", 1'b0, busy);
    check_bit("reset in_ready", 1'b1, in_ready);
    @(posedge clk);
    #1;
  endtask

  task automatic test_divide();
    operand_t a_v;
    operand_t b_v;
    for (int i = 0; i < 20; i++) begin
      a_v = rand_bits(W);
      // Random shift spreads the quotient sizes
      b_v = rand_bits(W) >> rand_bits(5);
      if (b_v == '0) begin
        b_v = operand_t'(1);
      end
      run_op($sformatf("div %0d", i), OP_DIV, a_v, b_v);
    end
  endtask

  task automatic test_sqrt();
    for (int i = 0; i < 20; i++) begin
      run_op($sformatf("sqrt %0d", i), OP_SQRT, rand_bits(W), '0);
    end
    run_op("sqrt zero", OP_SQRT, '0, '0);
    run_op("sqrt one", OP_SQRT, operand_t'(1), '0);
    run_op("sqrt ones", OP_SQRT, '1, '0);
  endtask

  task automatic test_div_zero();
    run_op("div by zero", OP_DIV, rand_bits(W), '0);
    run_op("zero by zero", OP_DIV, '0, '0);
  endtask

  task automatic test_backpressure();
    op_e         ops     [4];
    operand_t    as      [4];
    operand_t    bs      [4];
    operand_t    exp_res [4];
    status_t     exp_st  [4];
    int unsigned sent;
    int unsigned got;
    int unsigned cnt;
    logic        accept_in;
    logic        dropped;
    logic        held;
    operand_t    held_res;
    status_t     held_st;
    tag_t        held_tag;
    for (int i = 0; i < 4; i++) begin
      ops[i] = (i % 2 == 0) ? OP_DIV : OP_SQRT;
      as[i]  = rand_bits(W);
      bs[i]  = (ops[i] == OP_DIV) ? (rand_bits(W / 2) | operand_t'(1)) : '0;
      model_result(ops[i], as[i], bs[i], exp_res[i], exp_st[i]);
    end
    sent      = 0;
    got       = 0;
    dropped   = 1'b0;
    held      = 1'b0;
    out_ready = 1'b0;
    drive_request(ops[0], as[0], bs[0], tag_t'(8));
    // Stalled output, the held result must not move
    for (cnt = 0; cnt < 100; cnt++) begin
      @(negedge clk);
      if (!in_ready) begin
        dropped = 1'b1;
      end
      if (held) begin
        check_bit("hold out_valid", 1'b1, out_valid);
        check_operand("hold result", held_res, result);
        check_status("hold status", held_st, status);
        check_tag("hold tag", held_tag, tag_out);
      end
      held      = out_valid;
      held_res  = result;
      held_st   = status;
      held_tag  = tag_out;
      accept_in = in_valid & in_ready;
      @(posedge clk);
      #1;
      if (accept_in) begin
        sent++;
        if (sent < 4) begin
          drive_request(ops[sent], as[sent], bs[sent], tag_t'(8 + sent));
        end else begin
          in_valid = 1'b0;
        end
      end
    end
    check_bit("backpressure in_ready dropped", 1'b1, dropped);
    // Release and drain in order
    out_ready = 1'b1;
    cnt       = 0;
    while (got < 4) begin
      @(negedge clk);
      accept_in = in_valid & in_ready;
      if (out_valid) begin
        check_operand($sformatf("order %0d result", got), exp_res[got], result);
        check_status($sformatf("order %0d status", got), exp_st[got], status);
        check_tag($sformatf("order %0d tag", got), tag_t'(8 + got), tag_out);
        got++;
      end
      cnt++;
      if (cnt > 5 * Timeout) begin
        abort_run("Timeout: held results did not all drain");
      end
      @(posedge clk);
      #1;
      if (accept_in) begin
        sent++;
        if (sent < 4) begin
          drive_request(ops[sent], as[sent], bs[sent], tag_t'(8 + sent));
        end else begin
          in_valid = 1'b0;
        end
      end
    end
    // A duplicate would show up here
    for (cnt = 0; cnt < 50; cnt++) begin
      @(negedge clk);
      check_bit("no extra result", 1'b0, out_valid);
    end
    check_bit("backpressure busy", 1'b0, busy);
    @(posedge clk);
    #1;
  endtask

  task automatic test_flush();
    int unsigned cnt;
    send_request(OP_DIV, rand_bits(W), rand_bits(W / 2) | operand_t'(1), tag_t'(5));
    // Let the core get halfway through
    for (cnt = 0; cnt < 10; cnt++) begin
      @(negedge clk);
      check_bit("flush early out_valid", 1'b0, out_valid);
      @(posedge clk);
      #1;
    end
    @(negedge clk);
    check_bit("flush busy before", 1'b1, busy);
    @(posedge clk);
    #1;
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    cnt   = 0;
    @(negedge clk);
    while (busy) begin
      cnt++;
      if (cnt > Timeout) begin
        abort_run("Timeout: busy stayed high after flush");
      end
      @(negedge clk);
    end
    for (cnt = 0; cnt < 50; cnt++) begin
      check_bit("flushed result", 1'b0, out_valid);
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    run_op("sqrt after flush", OP_SQRT, rand_bits(W), '0);
  endtask

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------
  initial begin
    lfsr_q    = 32'hf870;
    rst       = 1'b1;
    flush     = 1'b0;
    in_valid  = 1'b0;
    op        = OP_DIV;
    a         = '0;
    b         = '0;
    tag       = '0;
    out_ready = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    test_reset();
    test_divide();
    test_sqrt();
    test_div_zero();
    test_backpressure();
    test_flush();

    $display("All tests passed");
    $finish;
  end

endmodule

/* divsqrt.f */
+incdir+common
common/divsqrt_pkg.sv
rtl/pipe_stages.sv
divsqrt/divsqrt_iter.sv
divsqrt/divsqrt_ctrl.sv
rtl/divsqrt_top.sv
sim/tb_divsqrt.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the divide / sqrt testbench with Verilator and runs it.
# Exits non-zero when the build fails or the log reports a failure.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_divsqrt --Mdir "$BUILD_DIR" -o tb_divsqrt \
  -f divsqrt.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_divsqrt" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

# The log decides the verdict
if grep -q "Some tests failed" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if ! grep -q "All tests passed" "$LOG"; then
  echo "Simulation ended without a verdict"
  exit 1
fi

exit 0
